/* files.f */
+incdir+include
logic/imgproc_pkg.sv
logic/stream_reg.sv
logic/pixel_classifier.sv
logic/scan_tracker.sv
logic/blob_tracker.sv
logic/msg_fifo.sv
logic/imgproc_regs.sv
logic/imgproc_top.sv
testbench/imgproc_tb.sv

/* include/imgproc_settings.svh */
`ifndef IMGPROC_SETTINGS_SVH
`define IMGPROC_SETTINGS_SVH

// frame geometry, coordinates are 11 bits
`define IMAGE_W 11'd640
`define IMAGE_H 11'd480

// per-line majority filter
`define DETECT_WINDOW 32
`define DETECT_MAJORITY 12
// narrowest run that may move the box
`define MIN_RUN 11'd60

// red thresholds on hue, saturation and value
`define HUE_MAX_RED 9'd38
`define SAT_MIN_RED 8'd145
`define VAL_MIN_RED 8'd47
`define RED_CODE 24'hff0000

// message path
`define MSG_INTERVAL 8'd6
`define MSG_DEPTH 256
`define MSG_TAG 8'h56

// register map
`define ADDR_STATUS 3'd0
`define ADDR_MSG 3'd1
`define ADDR_ID 3'd2
`define CORE_ID 32'h1234eee2

`endif

/* logic/blob_tracker.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module blob_tracker (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     accept,
	input  imgproc_pkg::pixel_beat_t beat,
	input  imgproc_pkg::scan_pos_t   pos,
	input  logic                     red_hit,
	input  logic [7:0]               gray,
	input  logic                     mode,
	output imgproc_pkg::rgb_t        pix_out,
	output imgproc_pkg::box_t        box
);

	localparam int CNT_W = $clog2(`DETECT_WINDOW + 1);

	logic [`DETECT_WINDOW-1:0] window;
	logic [`DETECT_WINDOW-1:0] window_now;
	logic [CNT_W-1:0] hit_count;
	logic in_band;
	logic filtered;
	logic edge_hit;
	logic is_pixel;
	logic video_eop;
	// run being built on this line
	logic [10:0] run_width;
	logic [10:0] run_left;
	logic [10:0] run_right;
	// widest run so far this frame
	logic [10:0] best_width;
	logic [10:0] best_left;
	logic [10:0] best_right;
	logic [11:0] left_sum;
	logic [11:0] right_sum;

	////////////////////
	// majority filter
	////////////////////

	// current detection shifted in, restarted at column 0
	assign window_now = (pos.x == 11'd0) ? {{(`DETECT_WINDOW - 1){1'b0}}, red_hit} :
		{window[`DETECT_WINDOW-2:0], red_hit};

	always_comb begin
		hit_count = '0;
		for (int i = 0; i < `DETECT_WINDOW; i++) begin
			hit_count = hit_count + CNT_W'(window_now[i]);
		end
	end

	// edges of the line never fill the window
	assign in_band = (pos.x > 11'(`DETECT_WINDOW)) &&
		(pos.x < `IMAGE_W - 11'(`DETECT_WINDOW));
	assign filtered = in_band && (hit_count > CNT_W'(`DETECT_MAJORITY));

	////////////////////
	// run and box
	////////////////////

	assign is_pixel = accept && !beat.sop;
	assign video_eop = accept && beat.eop && !beat.sop && pos.video;
	// smoothing, half old edge and half new edge
	assign left_sum = {1'b0, box.left} + {1'b0, best_left};
	assign right_sum = {1'b0, box.right} + {1'b0, best_right};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			window <= '0;
			run_width <= 11'd0;
			run_left <= `IMAGE_W - 11'd1;
			run_right <= 11'(`DETECT_WINDOW);
			best_width <= `MIN_RUN;
			best_left <= 11'd0;
			best_right <= 11'd0;
			box <= '0;
		end else begin
			if (accept && beat.sop) begin
				run_width <= 11'd0;
				run_left <= `IMAGE_W - 11'd1;
				run_right <= 11'(`DETECT_WINDOW);
				// runs must beat MIN_RUN to count
				best_width <= `MIN_RUN;
				best_left <= 11'd0;
				best_right <= 11'd0;
			end else if (is_pixel) begin
				window <= window_now;
				if (filtered) begin
					run_width <= run_width + 11'd1;
					if (pos.x < run_left) begin
						run_left <= pos.x;
					end
					run_right <= pos.x;
				end else begin
					// run ends, keep it if widest
					if (run_width > best_width) begin
						best_width <= run_width;
						best_left <= run_left;
						best_right <= run_right;
					end
					run_width <= 11'd0;
					run_left <= `IMAGE_W - 11'd1;
					run_right <= 11'(`DETECT_WINDOW);
				end
			end
			// box moves once per video frame
			if (video_eop && (best_right > best_left)) begin
				box.left <= left_sum[11:1];
				box.right <= right_sum[11:1];
			end
		end
	end

	////////////////////
	// overlay
	////////////////////

	// one edge only, a collapsed box draws nothing
	assign edge_hit = (box.left == pos.x) ^ (box.right == pos.x);

	always_comb begin
		if (mode && pos.video && !beat.sop) begin
			if (in_band && (filtered || edge_hit)) begin
				pix_out = `RED_CODE;
			end else begin
				pix_out = '{gray, gray, gray};
			end
		end else begin
			pix_out = beat.rgb;
		end
	end

endmodule

/* logic/imgproc_pkg.sv */
package imgproc_pkg;

	////////////////////
	// stream payload
	////////////////////

	// red sits in the top byte of the stream word
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic sop;
		logic eop;
	} pixel_beat_t;

	////////////////////
	// tracker types
	////////////////////

	// hue in degrees 0 to 359
	typedef struct packed {
		logic [8:0] hue;
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	typedef struct packed {
		logic [10:0] x;
		logic [10:0] y;
		logic video;
	} scan_pos_t;

	typedef struct packed {
		logic [10:0] left;
		logic [10:0] right;
	} box_t;

	// tag byte then sampled brightness total
	typedef struct packed {
		logic [7:0] tag;
		logic [23:0] total;
	} msg_word_t;

endpackage

/* logic/imgproc_regs.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module imgproc_regs (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   chipselect,
	input  logic                   read,
	input  logic                   write,
	input  logic [2:0]             address,
	input  logic [31:0]            writedata,
	output logic [31:0]            readdata,
	input  imgproc_pkg::msg_word_t head,
	input  logic                   empty,
	input  logic [8:0]             used,
	output logic                   pop,
	output logic                   flush
);

	// status byte, bit 4 is write-only flush
	logic [7:0] reg_status;
	logic read_d;
	logic [7:0] used_byte;
	logic status_wr;

	assign status_wr = chipselect && write && (address == `ADDR_STATUS);
	assign flush = status_wr && writedata[4];
	// pop once on the leading cycle of a message read
	assign pop = chipselect && read && !read_d && !empty && (address == `ADDR_MSG);
	// count field is one byte wide
	assign used_byte = used[8] ? 8'hff : used[7:0];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= 8'h00;
			readdata <= 32'h0;
			read_d <= 1'b0;
		end else begin
			read_d <= chipselect && read;
			if (status_wr) begin
				reg_status <= writedata[7:0] & 8'hef;
			end
			// read data lands one cycle after the request
			if (chipselect && read) begin
				case (address)
					`ADDR_STATUS: readdata <= {16'h0000, used_byte, reg_status};
					`ADDR_MSG: readdata <= head;
					`ADDR_ID: readdata <= `CORE_ID;
					default: readdata <= 32'h0;
				endcase
			end
		end
	end

endmodule

/* logic/imgproc_top.sv */
`timescale 1ns/100ps

module imgproc_top (
	input  logic        clk,
	input  logic        reset_n,
	// memory-mapped slave
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	output logic [31:0] s_readdata,
	input  logic [31:0] s_writedata,
	input  logic [2:0]  s_address,
	// stream sink
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	output logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,
	// stream source
	output logic [23:0] source_data,
	output logic        source_valid,
	input  logic        source_ready,
	output logic        source_sop,
	output logic        source_eop,
	// overlay enable
	input  logic        mode
);

	imgproc_pkg::pixel_beat_t sink_beat;
	imgproc_pkg::pixel_beat_t cur_beat;
	imgproc_pkg::pixel_beat_t out_beat;
	imgproc_pkg::pixel_beat_t source_beat;
	logic cur_valid;
	logic out_ready;
	logic accept;
	imgproc_pkg::hsv_t cur_hsv;
	logic [7:0] cur_gray;
	logic red_hit;
	imgproc_pkg::scan_pos_t cur_pos;
	imgproc_pkg::rgb_t pix_out;
	// tracked box, visible for debug
	imgproc_pkg::box_t track_box;
	logic msg_push;
	imgproc_pkg::msg_word_t msg_data;
	imgproc_pkg::msg_word_t msg_head;
	logic msg_empty;
	logic [8:0] msg_used;
	logic msg_pop;
	logic msg_flush;

	//////////////////////
	// stream path
	//////////////////////

	assign sink_beat = '{rgb: sink_data, sop: sink_sop, eop: sink_eop};
	// tracker state moves only when the pixel goes forward
	assign accept = cur_valid && out_ready;
	assign out_beat = '{rgb: pix_out, sop: cur_beat.sop, eop: cur_beat.eop};
	assign source_data = source_beat.rgb;
	assign source_sop = source_beat.sop;
	assign source_eop = source_beat.eop;

	stream_reg in_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (sink_valid),
		.ready_out (sink_ready),
		.data_in   (sink_beat),
		.valid_out (cur_valid),
		.ready_in  (out_ready),
		.data_out  (cur_beat)
	);

	pixel_classifier classifier_inst (
		.beat    (cur_beat),
		.hsv     (cur_hsv),
		.gray    (cur_gray),
		.red_hit (red_hit)
	);

	scan_tracker scan_inst (
		.clk      (clk),
		.reset_n  (reset_n),
		.beat     (cur_beat),
		.accept   (accept),
		.value    (cur_hsv.val),
		.msg_used (msg_used),
		.pos      (cur_pos),
		.msg_push (msg_push),
		.msg_data (msg_data)
	);

	blob_tracker blob_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.accept  (accept),
		.beat    (cur_beat),
		.pos     (cur_pos),
		.red_hit (red_hit),
		.gray    (cur_gray),
		.mode    (mode),
		.pix_out (pix_out),
		.box     (track_box)
	);

	stream_reg out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (cur_valid),
		.ready_out (out_ready),
		.data_in   (out_beat),
		.valid_out (source_valid),
		.ready_in  (source_ready),
		.data_out  (source_beat)
	);

	//////////////////////
	// CPU side
	//////////////////////

	msg_fifo fifo_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.clear   (msg_flush),
		.push    (msg_push),
		.data    (msg_data),
		.pop     (msg_pop),
		.head    (msg_head),
		.empty   (msg_empty),
		.used    (msg_used)
	);

	imgproc_regs regs_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.chipselect (s_chipselect),
		.read       (s_read),
		.write      (s_write),
		.address    (s_address),
		.writedata  (s_writedata),
		.readdata   (s_readdata),
		.head       (msg_head),
		.empty      (msg_empty),
		.used       (msg_used),
		.pop        (msg_pop),
		.flush      (msg_flush)
	);

endmodule

/* logic/msg_fifo.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module msg_fifo (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   clear,
	input  logic                   push,
	input  imgproc_pkg::msg_word_t data,
	input  logic                   pop,
	output imgproc_pkg::msg_word_t head,
	output logic                   empty,
	output logic [8:0]             used
);

	localparam int ADDR_W = $clog2(`MSG_DEPTH);

	imgproc_pkg::msg_word_t mem [`MSG_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty = (used == 9'd0);
	// overflow and underflow requests are dropped
	assign do_push = push && (used != 9'(`MSG_DEPTH));
	assign do_pop = pop && !empty;
	// show-ahead, head word valid whenever not empty
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= 9'd0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: used <= used + 9'd1;
				2'b01: used <= used - 9'd1;
				default: used <= used;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data;
		end
	end

endmodule

/* logic/pixel_classifier.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module pixel_classifier (
	input  imgproc_pkg::pixel_beat_t beat,
	output imgproc_pkg::hsv_t        hsv,
	output logic [7:0]               gray,
	output logic                     red_hit
);

	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic [7:0] max_c;
	logic [7:0] min_c;
	logic [7:0] delta;
	logic [7:0] num;
	logic [8:0] base;
	logic [7:0] den_h;
	logic [7:0] den_s;
	logic [13:0] scaled;
	logic [15:0] sat_q;

	assign r = beat.rgb.red;
	assign g = beat.rgb.green;
	assign b = beat.rgb.blue;

	// channel order picks one of six 60 degree sectors
	// ties go to red then green so num never passes delta
	always_comb begin
		if (r >= g && r >= b) begin
			max_c = r;
			if (g >= b) begin
				min_c = b;
				base = 9'd0;
				num = g - b;
			end else begin
				min_c = g;
				base = 9'd300;
				num = r - b;
			end
		end else if (g >= b) begin
			max_c = g;
			if (r >= b) begin
				min_c = b;
				base = 9'd60;
				num = g - r;
			end else begin
				min_c = r;
				base = 9'd120;
				num = b - r;
			end
		end else begin
			max_c = b;
			if (g >= r) begin
				min_c = r;
				base = 9'd180;
				num = b - g;
			end else begin
				min_c = g;
				base = 9'd240;
				num = r - g;
			end
		end
	end

	assign delta = max_c - min_c;
	// grey pixels would divide by zero
	assign den_h = (delta == 8'd0) ? 8'd1 : delta;
	assign den_s = (max_c == 8'd0) ? 8'd1 : max_c;
	assign scaled = (14'd60 * num) / den_h;
	assign sat_q = {delta, 8'h00} / den_s;

	assign hsv.hue = (delta == 8'd0) ? 9'd0 : base + scaled[8:0];
	// pure colour gives 256, clamp to full scale
	assign hsv.sat = (sat_q > 16'd255) ? 8'd255 : sat_q[7:0];
	assign hsv.val = max_c;

	// green/2 + red/4 + blue/4
	assign gray = {1'b0, g[7:1]} + {2'b00, r[7:2]} + {2'b00, b[7:2]};

	assign red_hit = (hsv.hue < `HUE_MAX_RED) && (hsv.sat > `SAT_MIN_RED) &&
		(hsv.val > `VAL_MIN_RED);

endmodule

/* logic/scan_tracker.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module scan_tracker (
	input  logic                     clk,
	input  logic                     reset_n,
	input  imgproc_pkg::pixel_beat_t beat,
	input  logic                     accept,
	input  logic [7:0]               value,
	input  logic [8:0]               msg_used,
	output imgproc_pkg::scan_pos_t   pos,
	output logic                     msg_push,
	output imgproc_pkg::msg_word_t   msg_data
);

	logic [23:0] value_total;
	// video frames left until the next message
	logic [7:0] frame_left;
	logic video_eop;
	logic msg_room;
	logic send_msg;

	assign video_eop = accept && beat.eop && !beat.sop && pos.video;
	// keep a few words of slack in the FIFO
	assign msg_room = msg_used < 9'(`MSG_DEPTH - 3);
	assign send_msg = video_eop && (frame_left == 8'd0) && msg_room;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pos <= '0;
			value_total <= '0;
			frame_left <= 8'd0;
			msg_push <= 1'b0;
		end else begin
			msg_push <= send_msg;
			if (accept) begin
				if (beat.sop) begin
					// header beat, packet type in blue low nibble
					pos.x <= 11'd0;
					pos.y <= 11'd0;
					pos.video <= (beat.rgb.blue[3:0] == 4'h0);
					value_total <= '0;
				end else if (pos.x == `IMAGE_W - 11'd1) begin
					pos.x <= 11'd0;
					pos.y <= (pos.y == `IMAGE_H - 11'd1) ? 11'd0 : pos.y + 11'd1;
				end else begin
					pos.x <= pos.x + 11'd1;
					// sample brightness every fourth column
					if (pos.x[1:0] == 2'b00) begin
						value_total <= value_total + 24'(value);
					end
				end
			end
			if (video_eop) begin
				if (send_msg) begin
					frame_left <= `MSG_INTERVAL - 8'd1;
				end else begin
					frame_left <= frame_left - 8'd1;
				end
			end
		end
	end

	// last column never samples so the total is final here
	always_ff @(posedge clk) begin
		if (send_msg) begin
			msg_data.tag <= `MSG_TAG;
			msg_data.total <= value_total;
		end
	end

endmodule

/* logic/stream_reg.sv */
`timescale 1ns/100ps

module stream_reg (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     valid_in,
	output logic                     ready_out,
	input  imgproc_pkg::pixel_beat_t data_in,
	output logic                     valid_out,
	input  logic                     ready_in,
	output imgproc_pkg::pixel_beat_t data_out
);

	// second slot catches the beat that arrives while downstream stalls
	imgproc_pkg::pixel_beat_t skid_data;
	logic skid_valid;
	logic take_in;
	logic load_main;

	// ready only depends on a flop
	assign ready_out = !skid_valid;
	assign take_in = valid_in && ready_out;
	// main slot empty or handing off this cycle
	assign load_main = !valid_out || ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
			skid_valid <= 1'b0;
		end else if (load_main) begin
			// skid drains first, input is blocked meanwhile
			valid_out <= skid_valid || take_in;
			skid_valid <= 1'b0;
		end else if (take_in) begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_main) begin
			data_out <= skid_valid ? skid_data : data_in;
		end else if (take_in) begin
			skid_data <= data_in;
		end
	end

endmodule

/* testbench/imgproc_tb.sv */
`timescale 1ns/100ps
`include "imgproc_settings.svh"

module imgproc_tb;

	// short frames at full line width so the window band applies
	localparam int ROWS = 3;
	localparam int LINE_W = `IMAGE_W;
	localparam int FRAME_BEATS = ROWS * LINE_W + 1;
	localparam int VIDEO_FRAMES = 13;
	localparam int OTHER_PIXELS = 100;
	// four cycles per beat cover random stalls plus CPU traffic and drains
	localparam int TIMEOUT_CYCLES = 4 * (VIDEO_FRAMES * FRAME_BEATS + OTHER_PIXELS + 1) + 4000;
	// solid red block columns
	localparam int BLOCK_LEFT = 200;
	localparam int BLOCK_RIGHT = 299;
	// filtered run that the block produces
	localparam int RUN_FIRST = BLOCK_LEFT + `DETECT_MAJORITY;
	localparam int RUN_LAST = BLOCK_RIGHT + `DETECT_WINDOW - `DETECT_MAJORITY - 1;

	logic clk;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [31:0] s_readdata;
	logic [31:0] s_writedata;
	logic [2:0] s_address;
	logic [23:0] sink_data;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	logic [23:0] source_data;
	logic source_valid;
	logic source_ready;
	logic source_sop;
	logic source_eop;
	logic mode;

	integer seed;
	int cycle_count;
	int error_count;
	int red_seen;
	logic bp_on;
	imgproc_pkg::pixel_beat_t expected_q[$];

	////////////////////
	// reference state
	////////////////////

	int ref_x;
	logic ref_video;
	logic [23:0] ref_total;
	logic line_hit [0:`IMAGE_W-1];
	int run_len;
	int run_start;
	int run_last;
	int best_len;
	int best_left;
	int best_right;
	int box_left;
	int box_right;
	// video frames until the next message
	int frames_left;
	logic [31:0] msg_q[$];

	imgproc_top imgproc_top_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_readdata   (s_readdata),
		.s_writedata  (s_writedata),
		.s_address    (s_address),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// failure reporting
	////////////////////

	task automatic stop_with_error(input string text);
		error_count++;
		$display("%s", text);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	////////////////////
	// colour reference
	////////////////////

	// signed position inside a 60 degree sector rounded toward lower hue
	function automatic int sector_offset(input int diff, input int span);
		if (diff >= 0) begin
			return (60 * diff) / span;
		end
		return -((60 * -diff + span - 1) / span);
	endfunction

	function automatic int hue_of(input logic [23:0] rgb);
		int r;
		int g;
		int b;
		int span;
		int h;
		r = rgb[23:16];
		g = rgb[15:8];
		b = rgb[7:0];
		span = max_of(rgb) - min_of(rgb);
		if (span == 0) begin
			return 0;
		end
		if (r >= g && r >= b) begin
			h = sector_offset(g - b, span);
			return (h < 0) ? h + 360 : h;
		end else if (g >= b) begin
			return 120 + sector_offset(b - r, span);
		end
		return 240 + sector_offset(r - g, span);
	endfunction

	function automatic int max_of(input logic [23:0] rgb);
		int m;
		m = rgb[23:16];
		m = (rgb[15:8] > m) ? rgb[15:8] : m;
		return (rgb[7:0] > m) ? rgb[7:0] : m;
	endfunction

	function automatic int min_of(input logic [23:0] rgb);
		int m;
		m = rgb[23:16];
		m = (rgb[15:8] < m) ? rgb[15:8] : m;
		return (rgb[7:0] < m) ? rgb[7:0] : m;
	endfunction

	function automatic logic is_red(input logic [23:0] rgb);
		int hi;
		int sat;
		hi = max_of(rgb);
		sat = (hi == 0) ? 0 : ((hi - min_of(rgb)) * 256) / hi;
		// full saturation clamps to 255
		sat = (sat > 255) ? 255 : sat;
		return (hue_of(rgb) < `HUE_MAX_RED) && (sat > `SAT_MIN_RED) && (hi > `VAL_MIN_RED);
	endfunction

	function automatic logic [7:0] gray_of(input logic [23:0] rgb);
		return (rgb[15:8] >> 1) + (rgb[23:16] >> 2) + (rgb[7:0] >> 2);
	endfunction

	function automatic logic [23:0] random_pixel(input logic avoid_red);
		logic [23:0] rgb;
		rgb = 24'($random(seed));
		// green up to red pushes hue to 60
		if (avoid_red && is_red(rgb)) begin
			rgb[15:8] = rgb[23:16];
		end
		return rgb;
	endfunction

	////////////////////
	// stream reference
	////////////////////

	task automatic model_beat(input logic [23:0] rgb, input logic sop, input logic eop);
		imgproc_pkg::pixel_beat_t exp_beat;
		int count;
		logic band;
		logic filt;
		logic on_edge;
		exp_beat.rgb = rgb;
		exp_beat.sop = sop;
		exp_beat.eop = eop;
		if (sop) begin
			// header beat passes unchanged and starts a frame
			ref_x = 0;
			ref_video = (rgb[3:0] == 4'h0);
			ref_total = '0;
			run_len = 0;
			best_len = `MIN_RUN;
			best_left = 0;
			best_right = 0;
		end else begin
			line_hit[ref_x] = is_red(rgb);
			count = 0;
			for (int c = ref_x - (`DETECT_WINDOW - 1); c <= ref_x; c++) begin
				if (c >= 0 && line_hit[c]) begin
					count++;
				end
			end
			band = (ref_x > `DETECT_WINDOW) && (ref_x < `IMAGE_W - `DETECT_WINDOW);
			filt = band && (count > `DETECT_MAJORITY);
			on_edge = (box_left == ref_x) != (box_right == ref_x);
			if (mode && ref_video) begin
				exp_beat.rgb = (band && (filt || on_edge)) ? `RED_CODE :
					{gray_of(rgb), gray_of(rgb), gray_of(rgb)};
			end
			// box and message see the state before this pixel
			if (eop && ref_video) begin
				if (best_right > best_left) begin
					box_left = (box_left + best_left) / 2;
					box_right = (box_right + best_right) / 2;
				end
				if (frames_left == 0 && msg_q.size() < `MSG_DEPTH - 3) begin
					msg_q.push_back({`MSG_TAG, ref_total});
					frames_left = `MSG_INTERVAL - 1;
				end else begin
					frames_left = frames_left - 1;
				end
			end
			if (filt) begin
				if (run_len == 0) begin
					run_start = ref_x;
				end
				run_len++;
				run_last = ref_x;
			end else begin
				if (run_len > best_len) begin
					best_len = run_len;
					best_left = run_start;
					best_right = run_last;
				end
				run_len = 0;
			end
			if (ref_x % 4 == 0 && ref_x != `IMAGE_W - 1) begin
				ref_total = ref_total + 24'(max_of(rgb));
			end
			ref_x = (ref_x == `IMAGE_W - 1) ? 0 : ref_x + 1;
		end
		expected_q.push_back(exp_beat);
	endtask

	////////////////////
	// stimulus
	////////////////////

	// ready is a flop and holds its value through the next edge
	task automatic send_beat(input logic [23:0] rgb, input logic sop, input logic eop);
		logic took;
		sink_data = rgb;
		sink_sop = sop;
		sink_eop = eop;
		sink_valid = 1'b1;
		took = 1'b0;
		while (!took) begin
			took = sink_ready;
			if (took) begin
				model_beat(rgb, sop, eop);
			end
			@(posedge clk);
			#1;
		end
	endtask

	// kind 0 random, 1 random without red, 2 red block on non-red
	task automatic send_frame(input int kind);
		logic [23:0] rgb;
		int x;
		send_beat(24'h000000, 1'b1, 1'b0);
		for (int i = 0; i < ROWS * LINE_W; i++) begin
			x = i % LINE_W;
			rgb = random_pixel(kind != 0);
			if (kind == 2 && x >= BLOCK_LEFT && x <= BLOCK_RIGHT) begin
				rgb = `RED_CODE;
			end
			send_beat(rgb, 1'b0, i == ROWS * LINE_W - 1);
		end
		sink_valid = 1'b0;
	endtask

	task automatic send_other_packet;
		// blue low nibble non-zero marks a non-video packet
		send_beat(24'h00000a, 1'b1, 1'b0);
		for (int i = 0; i < OTHER_PIXELS; i++) begin
			send_beat(random_pixel(1'b0), 1'b0, i == OTHER_PIXELS - 1);
		end
		sink_valid = 1'b0;
	endtask

	task automatic wait_drained;
		while (expected_q.size() != 0) begin
			@(posedge clk);
		end
		// message push lags the eop by two cycles
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic cpu_read(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		data = s_readdata;
		@(posedge clk);
		#1;
	endtask

	task automatic cpu_write(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic check_status(input int used_words, input string what);
		logic [31:0] word;
		cpu_read(`ADDR_STATUS, word);
		check_value(word, {16'h0000, 8'(used_words), 8'h00}, what);
	endtask

	////////////////////
	// source side
	////////////////////

	initial begin
		imgproc_pkg::pixel_beat_t want;
		forever begin
			@(posedge clk);
			#1;
			source_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
			if (source_valid && source_ready) begin
				if (expected_q.size() == 0) begin
					stop_with_error("the source sent a beat that no sink beat accounts for");
				end else begin
					want = expected_q.pop_front();
					check_value({6'b0, source_sop, source_eop, source_data},
						{6'b0, want.sop, want.eop, want.rgb}, "source beat");
					if (source_data == `RED_CODE) begin
						red_seen++;
					end
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > TIMEOUT_CYCLES) begin
				stop_with_error("timeout, the stream and register traffic did not finish in time");
			end
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		logic [31:0] word;
		logic [31:0] want_msg;
		seed = 23;
		error_count = 0;
		red_seen = 0;
		bp_on = 1'b0;
		reset_n = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_writedata = 32'h0;
		s_address = 3'd0;
		sink_data = 24'h0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b0;
		mode = 1'b0;
		ref_x = 0;
		ref_video = 1'b0;
		ref_total = '0;
		run_len = 0;
		best_len = `MIN_RUN;
		best_left = 0;
		best_right = 0;
		box_left = 0;
		box_right = 0;
		frames_left = 0;
		repeat (8) @(posedge clk);
		#1;
		reset_n = 1'b1;
		bp_on = 1'b1;
		@(posedge clk);
		#1;
		// sink ready high, source valid low
		check_value({30'b0, sink_ready, source_valid}, 32'h2, "handshake after reset");
		check_value(s_readdata, 32'h0, "read data after reset");
		// pass-through frame sends the first message
		send_frame(0);
		wait_drained();
		check_status(1, "status with one stored message");
		cpu_read(`ADDR_MSG, word);
		want_msg = msg_q.pop_front();
		check_value(word, want_msg, "first message word");
		check_status(0, "status after message read");
		// grey overlay then a non-video packet
		mode = 1'b1;
		send_frame(1);
		send_other_packet();
		wait_drained();
		check_status(0, "status after second video frame");
		red_seen = 0;
		send_frame(2);
		wait_drained();
		check_value(red_seen, ROWS * (RUN_LAST - RUN_FIRST + 1), "filtered pixels in block frame");
		// box now halfway from zero to the run edges
		red_seen = 0;
		send_frame(1);
		wait_drained();
		check_value(red_seen, 2 * ROWS, "box edge pixels");
		check_value({10'b0, imgproc_top_inst.track_box},
			{10'b0, 11'(RUN_FIRST / 2), 11'(RUN_LAST / 2)}, "tracked box edges");
		mode = 1'b0;
		for (int f = 5; f <= VIDEO_FRAMES; f++) begin
			send_frame(0);
			wait_drained();
			check_status((f - 1) / `MSG_INTERVAL, $sformatf("status after video frame %0d", f));
		end
		cpu_read(`ADDR_ID, word);
		check_value(word, `CORE_ID, "core id");
		cpu_write(`ADDR_STATUS, 32'h0000_0010);
		msg_q.delete();
		check_status(0, "status after flush");
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
